//--- rtl/bus_arbiter.sv
`timescale 1ns/100ps

module bus_arbiter import soc_pkg::*; (
    input  logic     pll_clk,
    input  logic     arst_n,

    input  mem_req_t instr_req,
    output mem_rsp_t instr_rsp,

    input  mem_req_t data_req,
    output mem_rsp_t data_rsp,

    output mem_req_t bus_req,
    output logic     bus_valid,
    input  mem_rsp_t bus_rsp
);

    arb_state_t state;
    arb_state_t state_next;
    logic       instr_pending;
    logic       data_pending;

    assign instr_pending = instr_req.read | instr_req.write;
    assign data_pending  = data_req.read | data_req.write;

    always_comb begin
        state_next = state;
        case (state)
            ARB_IDLE: begin
                if (data_pending) begin
                    state_next = ARB_DATA; // Data port wins a tie.
                end else if (instr_pending) begin
                    state_next = ARB_INSTR;
                end
            end
            ARB_INSTR, ARB_DATA: begin
                if (bus_rsp.ready) begin
                    state_next = ARB_IDLE; // Forces one idle cycle between accesses.
                end
            end
            default: begin
                state_next = ARB_IDLE;
            end
        endcase
    end

    always_ff @(posedge pll_clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= ARB_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign bus_valid = (state == ARB_INSTR) || (state == ARB_DATA);

    always_comb begin
        bus_req = '0;
        case (state)
            ARB_INSTR: begin
                bus_req = instr_req;
                bus_req.write = 1'b0; // Fetch port never writes.
            end
            ARB_DATA: begin
                bus_req = data_req;
            end
            default: begin
                bus_req = '0;
            end
        endcase
    end

    // Only the granted master sees the response.
    always_comb begin
        instr_rsp = '0;
        data_rsp  = '0;
        if (state == ARB_INSTR) begin
            instr_rsp = bus_rsp;
        end
        if (state == ARB_DATA) begin
            data_rsp = bus_rsp;
        end
    end

endmodule

//--- rtl/bus_decoder.sv
`timescale 1ns/100ps

module bus_decoder import soc_pkg::*; (
    input  mem_req_t    bus_req,
    input  logic        bus_valid,
    output mem_rsp_t    bus_rsp,

    output logic        ram_sel,
    output logic        leds_sel,
    output logic        timer_sel,

    input  logic [31:0] ram_rdata,
    input  logic [31:0] leds_rdata,
    input  logic [31:0] timer_rdata,
    input  logic        ram_ready
);

    region_t region;
    logic    fault;

    function automatic logic in_window(
        input logic [31:0] addr,
        input logic [31:0] base,
        input logic [31:0] size
    );
        return (addr & ~(size - 32'd1)) == base;
    endfunction

    always_comb begin
        if (in_window(bus_req.address, RAM_BASE, RAM_SIZE)) begin
            region = REG_RAM;
        end else if (in_window(bus_req.address, LEDS_BASE, LEDS_SIZE)) begin
            region = REG_LEDS;
        end else if (in_window(bus_req.address, TIMER_BASE, TIMER_SIZE)) begin
            region = REG_TIMER;
        end else begin
            region = REG_NONE;
        end
    end

    assign ram_sel   = bus_valid && (region == REG_RAM);
    assign leds_sel  = bus_valid && (region == REG_LEDS);
    assign timer_sel = bus_valid && (region == REG_TIMER);
    assign fault     = bus_valid && (region == REG_NONE);

    // Unselected slaves drive zero, so an OR merges the read data.
    assign bus_rsp.read_value = ram_rdata | leds_rdata | timer_rdata;
    assign bus_rsp.ready      = ram_ready | leds_sel | timer_sel | fault;
    assign bus_rsp.fault      = fault;

endmodule

//--- rtl/led_port.sv
`timescale 1ns/100ps

module led_port (
    input  logic        pll_clk,
    input  logic        arst_n,
    input  logic        sel,
    input  logic        write,
    input  logic [3:0]  write_mask,
    input  logic [31:0] write_value,
    output logic [31:0] rdata,
    output logic [7:0]  leds
);

    always_ff @(posedge pll_clk or negedge arst_n) begin
        if (!arst_n) begin
            leds <= 8'd0;
        end else if (sel && write && write_mask[0]) begin
            leds <= write_value[7:0]; // Only byte 0 is backed.
        end
    end

    assign rdata = sel ? {24'd0, leds} : 32'd0;

endmodule

//--- rtl/ram.sv
`timescale 1ns/100ps

module ram import soc_pkg::*; #(
    parameter int ram_words = 1024
) (
    input  logic        pll_clk,
    input  logic        sel,
    input  logic [31:0] word_addr,
    input  logic        write,
    input  logic [3:0]  write_mask,
    input  logic [31:0] write_value,
    output logic [31:0] rdata,
    output logic        ready
);

    localparam int index_bits = $clog2(ram_words);

    logic [31:0]           mem [ram_words];
    logic [index_bits-1:0] index;
    logic [31:0]           word_q;
    logic                  ready_q;

    assign index = word_addr[index_bits-1:0]; // Upper bits alias the window.

    always_ff @(posedge pll_clk) begin
        if (sel && write) begin
            mem[index] <= apply_mask(mem[index], write_mask, write_value);
        end
        if (sel) begin
            word_q <= mem[index];
        end
    end

    // Toggles so a held select gives one ready pulse.
    always_ff @(posedge pll_clk) begin
        ready_q <= sel && !ready_q;
    end

    assign ready = ready_q;
    assign rdata = ready_q ? word_q : 32'd0;

endmodule

//--- rtl/soc_bus_top.sv
`timescale 1ns/100ps

module soc_bus_top import soc_pkg::*; #(
    parameter int ram_words = 1024
) (
    input  logic       pll_clk,
    input  logic       arst_n,
    input  mem_req_t   instr_req,
    output mem_rsp_t   instr_rsp,
    input  mem_req_t   data_req,
    output mem_rsp_t   data_rsp,
    output logic [7:0] leds,
    output logic       timer_irq
);

    mem_req_t    bus_req;
    logic        bus_valid;
    mem_rsp_t    bus_rsp;

    logic        ram_sel;
    logic        leds_sel;
    logic        timer_sel;
    logic [31:0] ram_rdata;
    logic [31:0] leds_rdata;
    logic [31:0] timer_rdata;
    logic        ram_ready;

    bus_arbiter u_arbiter (
        .pll_clk   (pll_clk),
        .arst_n    (arst_n),
        .instr_req (instr_req),
        .instr_rsp (instr_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .bus_req   (bus_req),
        .bus_valid (bus_valid),
        .bus_rsp   (bus_rsp)
    );

    bus_decoder u_decoder (
        .bus_req     (bus_req),
        .bus_valid   (bus_valid),
        .bus_rsp     (bus_rsp),
        .ram_sel     (ram_sel),
        .leds_sel    (leds_sel),
        .timer_sel   (timer_sel),
        .ram_rdata   (ram_rdata),
        .leds_rdata  (leds_rdata),
        .timer_rdata (timer_rdata),
        .ram_ready   (ram_ready)
    );

    ram #(
        .ram_words (ram_words)
    ) u_ram (
        .pll_clk     (pll_clk),
        .sel         (ram_sel),
        .word_addr   ({2'b00, bus_req.address[31:2]}), // Byte to word address.
        .write       (bus_req.write),
        .write_mask  (bus_req.write_mask),
        .write_value (bus_req.write_value),
        .rdata       (ram_rdata),
        .ready       (ram_ready)
    );

    led_port u_leds (
        .pll_clk     (pll_clk),
        .arst_n      (arst_n),
        .sel         (leds_sel),
        .write       (bus_req.write),
        .write_mask  (bus_req.write_mask),
        .write_value (bus_req.write_value),
        .rdata       (leds_rdata),
        .leds        (leds)
    );

    timer u_timer (
        .pll_clk     (pll_clk),
        .arst_n      (arst_n),
        .sel         (timer_sel),
        .offset      (bus_req.address[3:0]),
        .write       (bus_req.write),
        .write_mask  (bus_req.write_mask),
        .write_value (bus_req.write_value),
        .rdata       (timer_rdata),
        .timer_irq   (timer_irq)
    );

endmodule

//--- rtl/soc_pkg.sv
package soc_pkg;

    typedef struct packed {
        logic [31:0] address;
        logic        read;
        logic        write;
        logic [3:0]  write_mask;
        logic [31:0] write_value;
    } mem_req_t;

    typedef struct packed {
        logic [31:0] read_value;
        logic        ready;
        logic        fault;
    } mem_rsp_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_INSTR,
        ARB_DATA
    } arb_state_t;

    typedef enum logic [1:0] {
        REG_RAM,
        REG_LEDS,
        REG_TIMER,
        REG_NONE
    } region_t;

    // Windows are power-of-two sized and aligned to their size.
    localparam logic [31:0] RAM_BASE   = 32'h0000_0000;
    localparam logic [31:0] RAM_SIZE   = 32'h0001_0000; // 64 KiB.
    localparam logic [31:0] LEDS_BASE  = 32'h0001_0000;
    localparam logic [31:0] LEDS_SIZE  = 32'h0000_0004; // One word.
    localparam logic [31:0] TIMER_BASE = 32'h0003_0000;
    localparam logic [31:0] TIMER_SIZE = 32'h0000_0010;

    // Replaces each byte of old_value whose mask bit is set.
    function automatic logic [31:0] apply_mask(
        input logic [31:0] old_value,
        input logic [3:0]  mask,
        input logic [31:0] new_value
    );
        logic [31:0] merged;
        merged = old_value;
        for (int i = 0; i < 4; i++) begin
            if (mask[i]) begin
                merged[8*i +: 8] = new_value[8*i +: 8];
            end
        end
        return merged;
    endfunction

endpackage

//--- rtl/timer.sv
`timescale 1ns/100ps

module timer import soc_pkg::*; (
    input  logic        pll_clk,
    input  logic        arst_n,
    input  logic        sel,
    input  logic [3:0]  offset,
    input  logic        write,
    input  logic [3:0]  write_mask,
    input  logic [31:0] write_value,
    output logic [31:0] rdata,
    output logic        timer_irq
);

    logic [63:0] counter;
    logic [63:0] compare;
    logic [31:0] reg_value;

    always_ff @(posedge pll_clk or negedge arst_n) begin
        if (!arst_n) begin
            counter <= 64'd0;
        end else begin
            counter <= counter + 64'd1;
        end
    end

    // Offsets 0 and 4 hold the counter and ignore writes.
    always_ff @(posedge pll_clk or negedge arst_n) begin
        if (!arst_n) begin
            compare <= '1; // Far future keeps the interrupt low out of reset.
        end else if (sel && write) begin
            case (offset[3:2])
                2'd2: begin
                    compare[31:0] <= apply_mask(compare[31:0], write_mask, write_value);
                end
                2'd3: begin
                    compare[63:32] <= apply_mask(compare[63:32], write_mask, write_value);
                end
                default: begin
                    compare <= compare;
                end
            endcase
        end
    end

    always_comb begin
        case (offset[3:2])
            2'd0:    reg_value = counter[31:0];
            2'd1:    reg_value = counter[63:32];
            2'd2:    reg_value = compare[31:0];
            default: reg_value = compare[63:32];
        endcase
    end

    assign rdata = sel ? reg_value : 32'd0;

    always_ff @(posedge pll_clk or negedge arst_n) begin
        if (!arst_n) begin
            timer_irq <= 1'b0;
        end else begin
            timer_irq <= counter >= compare; // Level held until compare moves up.
        end
    end

endmodule

//--- sim.f
rtl/soc_pkg.sv
rtl/bus_arbiter.sv
rtl/bus_decoder.sv
rtl/ram.sv
rtl/led_port.sv
rtl/timer.sv
rtl/soc_bus_top.sv
tests/bus_checker.sv
tests/tb_top.sv

//--- tests/bus_checker.sv
`timescale 1ns/100ps

module bus_checker import soc_pkg::*; (
    input  logic        pll_clk,
    input  logic        arst_n,
    input  mem_req_t    instr_req,
    input  mem_rsp_t    instr_rsp,
    input  mem_req_t    data_req,
    input  mem_rsp_t    data_rsp,
    input  logic [7:0]  leds,
    input  logic        timer_irq,
    input  int          entry_id,
    input  logic        on_data,
    input  logic        on_instr,
    input  logic [31:0] data_exp,
    input  logic [31:0] instr_exp,
    input  logic        fault_exp,
    input  logic [7:0]  leds_exp,
    input  logic [3:0]  checks,     // Value, counter rise, irq check, irq level.
    input  logic        entry_done,
    output logic        check_ack,
    output int          passed_count,
    output int          failed_count
);

    int          errors;
    int          wait_cycles;
    logic        data_seen;
    logic        instr_seen;
    logic [31:0] last_count;
    logic [31:0] row_addr;

    task automatic compare_value(
        input string       name,
        input logic [31:0] expected,
        input logic [31:0] actual
    );
        if (actual !== expected) begin
            $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
            errors++;
        end
    endtask

    always @(posedge pll_clk) begin
        if (arst_n && data_rsp.ready) begin
            row_addr = data_req.address;
            if (!on_data) begin
                $display("Unexpected response on the data port at %0t", $time);
                errors++;
            end else begin
                compare_value("data_rsp.fault", fault_exp, data_rsp.fault);
                if (checks[3]) begin
                    compare_value("data_rsp.read_value", data_exp, data_rsp.read_value);
                end
                if (checks[2]) begin
                    if (data_rsp.read_value <= last_count) begin
                        $display("Timer counter did not increase at %0t: %h after %h",
                                 $time, data_rsp.read_value, last_count);
                        errors++;
                    end
                    last_count = data_rsp.read_value;
                end
            end
            data_seen = 1'b1;
        end
        if (arst_n && instr_rsp.ready) begin
            row_addr = instr_req.address;
            if (!on_instr) begin
                $display("Unexpected response on the instruction port at %0t", $time);
                errors++;
            end else begin
                compare_value("instr_rsp.fault", fault_exp, instr_rsp.fault);
                if (checks[3]) begin
                    compare_value("instr_rsp.read_value", instr_exp, instr_rsp.read_value);
                end
                if (on_data && !data_seen) begin
                    $display("Instruction response came before the data response at %0t", $time);
                    errors++;
                end
            end
            instr_seen = 1'b1;
        end
    end

    initial begin
        errors       = 0;
        passed_count = 0;
        failed_count = 0;
        data_seen    = 1'b0;
        instr_seen   = 1'b0;
        last_count   = '0;
        row_addr     = '0;
        check_ack    = 1'b0;
        forever begin
            @(posedge pll_clk);
            if (entry_done) begin
                if ((on_data && !data_seen) || (on_instr && !instr_seen)) begin
                    $display("Row %0d finished without every expected response", entry_id);
                    errors++;
                end
                compare_value("leds", leds_exp, leds);
                if (checks[1]) begin
                    wait_cycles = 0;
                    while (timer_irq !== checks[0] && wait_cycles < 6) begin
                        @(posedge pll_clk);
                        wait_cycles++;
                    end
                    if (timer_irq !== checks[0]) begin
                        $display("** Error at %0t: timer_irq expected %b, got %b",
                                 $time, checks[0], timer_irq);
                        errors++;
                    end
                end
                if (errors == 0) begin
                    passed_count++;
                    $display("Row %0d at %h passed", entry_id, row_addr);
                end else begin
                    failed_count++;
                    $display("Row %0d at %h failed with %0d errors", entry_id, row_addr, errors);
                end
                errors     = 0;
                data_seen  = 1'b0;
                instr_seen = 1'b0;
                check_ack <= 1'b1;
                @(posedge pll_clk);
                check_ack <= 1'b0;
            end
        end
    end

endmodule

//--- tests/tb_top.sv
`timescale 1ns/100ps

module tb_top import soc_pkg::*; ();

    localparam int ram_words  = 1024;
    localparam int clk_period = 8;

    localparam logic [1:0] DATA  = 2'b01;
    localparam logic [1:0] INSTR = 2'b10;
    localparam logic [1:0] PAIR  = 2'b11;

    localparam logic [3:0] SKIP     = 4'b0000;
    localparam logic [3:0] CMP      = 4'b1000;
    localparam logic [3:0] RISE     = 4'b0100; // Counter must exceed the last read.
    localparam logic [3:0] IRQ_LOW  = 4'b0010;
    localparam logic [3:0] IRQ_HIGH = 4'b0011;

    typedef struct packed {
        logic [1:0]  port;
        logic        write;
        logic [31:0] address;       // Data port address.
        logic [3:0]  mask;
        logic [31:0] value;
        logic [31:0] instr_address;
        logic [31:0] data_exp;
        logic [31:0] instr_exp;
        logic        fault;
        logic [7:0]  leds;
        logic [3:0]  checks;
        logic        from_count;    // Write value is the last counter read.
    } row_t;

    logic        pll_clk;
    logic        arst_n;
    mem_req_t    instr_req;
    mem_rsp_t    instr_rsp;
    mem_req_t    data_req;
    mem_rsp_t    data_rsp;
    logic [7:0]  leds;
    logic        timer_irq;

    row_t        rows[$];
    row_t        active_row;
    int          row_index;
    logic        entry_done;
    logic        check_ack;
    int          passed_count;
    int          failed_count;
    logic        rows_built;
    logic [31:0] lfsr_state;
    logic [31:0] last_count;

    soc_bus_top #(
        .ram_words (ram_words)
    ) DUT (
        .pll_clk   (pll_clk),
        .arst_n    (arst_n),
        .instr_req (instr_req),
        .instr_rsp (instr_rsp),
        .data_req  (data_req),
        .data_rsp  (data_rsp),
        .leds      (leds),
        .timer_irq (timer_irq)
    );

    bus_checker u_checker (
        .pll_clk      (pll_clk),
        .arst_n       (arst_n),
        .instr_req    (instr_req),
        .instr_rsp    (instr_rsp),
        .data_req     (data_req),
        .data_rsp     (data_rsp),
        .leds         (leds),
        .timer_irq    (timer_irq),
        .entry_id     (row_index),
        .on_data      (active_row.port[0]),
        .on_instr     (active_row.port[1]),
        .data_exp     (active_row.data_exp),
        .instr_exp    (active_row.instr_exp),
        .fault_exp    (active_row.fault),
        .leds_exp     (active_row.leds),
        .checks       (active_row.checks),
        .entry_done   (entry_done),
        .check_ack    (check_ack),
        .passed_count (passed_count),
        .failed_count (failed_count)
    );

    initial begin
        pll_clk = 1'b0;
        forever #(clk_period / 2) pll_clk = ~pll_clk;
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic lfsr_bit();
        logic feedback;
        feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [31:0] random_word();
        logic [31:0] word;
        word = '0;
        for (int i = 0; i < 32; i++) begin
            word = {word[30:0], lfsr_bit()};
        end
        return word;
    endfunction

    task automatic add_row(
        input logic [1:0]  port,
        input logic        write,
        input logic [31:0] address,
        input logic [3:0]  mask,
        input logic [31:0] value,
        input logic [31:0] instr_address,
        input logic [31:0] data_exp,
        input logic [31:0] instr_exp,
        input logic        fault,
        input logic [7:0]  leds,
        input logic [3:0]  checks,
        input logic        from_count
    );
        row_t r;
        r = {port, write, address, mask, value, instr_address, data_exp, instr_exp,
             fault, leds, checks, from_count};
        rows.push_back(r);
    endtask

    task automatic build_rows();
        logic [31:0] full;
        logic [31:0] half;
        logic [31:0] fetch;
        logic [31:0] spare;
        logic [31:0] merged;
        logic [31:0] ram_a;
        logic [31:0] ram_b;
        logic [31:0] wrap;
        full   = random_word();
        half   = random_word();
        fetch  = random_word();
        spare  = random_word();
        merged = (full & 32'hff00_ff00) | (half & 32'h00ff_00ff); // Mask 0101.
        ram_a  = RAM_BASE + 32'h100;
        ram_b  = RAM_BASE + 32'h200;
        wrap   = ram_words * 4;
        add_row(DATA,  1, ram_a, 4'hf, full, 0, 0, 0, 0, 8'h00, SKIP | IRQ_LOW, 0);
        add_row(DATA,  1, ram_a, 4'h5, half, 0, 0, 0, 0, 8'h00, SKIP, 0);
        add_row(DATA,  0, ram_a, 4'h0, 0, 0, merged, 0, 0, 8'h00, CMP, 0);
        add_row(DATA,  0, ram_a + wrap, 4'h0, 0, 0, merged, 0, 0, 8'h00, CMP, 0);
        add_row(DATA,  1, ram_b, 4'hf, fetch, 0, 0, 0, 0, 8'h00, SKIP, 0);
        add_row(INSTR, 0, 0, 4'h0, 0, ram_b, 0, fetch, 0, 8'h00, CMP, 0);
        add_row(DATA,  1, LEDS_BASE, 4'h1, 32'h1234_56a5, 0, 0, 0, 0, 8'ha5, SKIP, 0);
        add_row(DATA,  1, LEDS_BASE, 4'he, 32'h0000_003c, 0, 0, 0, 0, 8'ha5, SKIP, 0);
        add_row(DATA,  0, LEDS_BASE, 4'h0, 0, 0, 32'ha5, 0, 0, 8'ha5, CMP, 0);
        add_row(DATA,  1, RAM_BASE, 4'hf, spare, 0, 0, 0, 0, 8'ha5, SKIP, 0);
        add_row(DATA,  1, 32'h0002_0000, 4'hf, 32'hffff_ffff, 0, 0, 0, 1, 8'ha5, CMP, 0);
        add_row(DATA,  1, 32'h0200_0000, 4'h1, 32'h0000_005a, 0, 0, 0, 1, 8'ha5, CMP, 0);
        add_row(DATA,  0, 32'h0002_0000, 4'h0, 0, 0, 0, 0, 1, 8'ha5, CMP, 0);
        add_row(INSTR, 0, 0, 4'h0, 0, 32'h0200_0000, 0, 0, 1, 8'ha5, CMP, 0);
        add_row(DATA,  0, RAM_BASE, 4'h0, 0, 0, spare, 0, 0, 8'ha5, CMP, 0);
        add_row(PAIR,  0, ram_a, 4'h0, 0, ram_b, merged, fetch, 0, 8'ha5, CMP, 0);
        add_row(PAIR,  0, LEDS_BASE, 4'h0, 0, RAM_BASE, 32'ha5, spare, 0, 8'ha5, CMP, 0);
        add_row(DATA,  0, TIMER_BASE, 4'h0, 0, 0, 0, 0, 0, 8'ha5, RISE | IRQ_LOW, 0);
        add_row(DATA,  0, TIMER_BASE, 4'h0, 0, 0, 0, 0, 0, 8'ha5, RISE, 0);
        add_row(DATA,  1, TIMER_BASE + 12, 4'hf, 0, 0, 0, 0, 0, 8'ha5, IRQ_LOW, 0);
        add_row(DATA,  1, TIMER_BASE + 8, 4'hf, 0, 0, 0, 0, 0, 8'ha5, IRQ_HIGH, 1);
        add_row(DATA,  1, TIMER_BASE + 12, 4'hf, 32'hffff_ffff, 0, 0, 0, 0, 8'ha5, IRQ_LOW, 0);
    endtask

    task automatic run_row(input row_t r);
        logic data_open;
        logic instr_open;
        data_open  = r.port[0];
        instr_open = r.port[1];
        if (r.from_count) begin
            r.value = last_count;
        end
        @(posedge pll_clk);
        active_row <= r;
        if (data_open) begin
            data_req <= {r.address, !r.write, r.write, r.mask, r.value};
        end
        if (instr_open) begin
            instr_req <= {r.instr_address, 1'b1, 1'b0, 4'h0, 32'h0};
        end
        while (data_open || instr_open) begin
            @(posedge pll_clk);
            if (data_open && data_rsp.ready) begin
                data_open = 1'b0;
                data_req <= '0;
                if (!r.write && r.address == TIMER_BASE) begin
                    last_count = data_rsp.read_value;
                end
            end
            if (instr_open && instr_rsp.ready) begin
                instr_open = 1'b0;
                instr_req <= '0;
            end
        end
        entry_done <= 1'b1;
        @(posedge pll_clk);
        entry_done <= 1'b0;
        while (!check_ack) begin
            @(posedge pll_clk);
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        instr_req  = '0;
        data_req   = '0;
        entry_done = 1'b0;
        active_row = '0;
        row_index  = 0;
        last_count = '0;
        rows_built = 1'b0;
        lfsr_state = 32'h6cfb_db13;
        build_rows();
        rows_built = 1'b1;
        repeat (4) @(posedge pll_clk);
        arst_n <= 1'b1;
        for (row_index = 0; row_index < rows.size(); row_index++) begin
            run_row(rows[row_index]);
        end
        @(posedge pll_clk);
        $display("Rows: %0d passed, %0d failed", passed_count, failed_count);
        if (failed_count == 0 && passed_count == rows.size()) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

    initial begin
        wait (rows_built);
        repeat (4 + rows.size() * 20) @(posedge pll_clk);
        $display("Run timed out after %0d rows of 20 cycles each", rows.size());
        $display("Result: FAILED");
        $finish;
    end

endmodule
